//--- Bender.yml
package:
  name: weight_load

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/weight_load_pkg.sv
      - source/weight_fifo.sv
      - source/weight_load_ctrl.sv
      - source/weight_burst_reader.sv
      - source/weight_buffer_writer.sv
      - source/weight_load_top.sv
  - target: any(simulation, test)
    include_dirs:
      - source
    files:
      - bench/ext_mem_model.sv
      - bench/tb_weight_load.sv

//--- bench/ext_mem_model.sv
// external memory model for the weight loader testbench
// random grant gaps, read data returns in order 1 to 4 cycles after the grant

`timescale 1ns/10ps

module ext_mem_model (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rd_en,
    input  weight_load_pkg::xaddr_t rd_addr,
    output logic                    grant,
    output logic                    rd_valid,
    output weight_load_pkg::word_t  rd_data
);

    import weight_load_pkg::*;

    int unsigned cycle;
    int unsigned last_ready;    // return cycle of the youngest read
    int unsigned ready_at;
    int unsigned ready_q[$];    // return cycle of each read in flight
    word_t       data_q[$];

    initial begin
        grant      = 1'b0;
        rd_valid   = 1'b0;
        rd_data    = '0;
        cycle      = 0;
        last_ready = 0;
        // grant decided here applies to the next rising edge
        forever begin
            @(negedge clk or posedge rst);
            if (rst) begin
                grant      = 1'b0;
                rd_valid   = 1'b0;
                rd_data    = '0;
                cycle      = 0;
                last_ready = 0;
                ready_q.delete();
                data_q.delete();
            end else begin
                cycle = cycle + 1;
                if (ready_q.size() != 0 && ready_q[0] <= cycle) begin
                    void'(ready_q.pop_front());
                    rd_data  = data_q.pop_front();
                    rd_valid = 1'b1;
                end else begin
                    rd_valid = 1'b0;
                end
                grant = ($urandom_range(3, 0) != 0);   // roughly one gap in four
                if (grant && rd_en) begin
                    ready_at = cycle + $urandom_range(4, 1);
                    if (ready_at <= last_ready) begin
                        ready_at = last_ready + 1;      // keep request order
                    end
                    last_ready = ready_at;
                    ready_q.push_back(ready_at);
                    data_q.push_back((rd_addr >> 2) ^ 32'h5a5a0000);
                end
            end
        end
    end

endmodule

//--- bench/tb_weight_load.sv
// testbench for the weight loader: random tile bases, grant gaps, latency
// and compute stalls, reads and buffer contents checked against the address rule

`timescale 1ns/10ps

`include "weight_load_params.svh"

module tb_weight_load;

    import weight_load_pkg::*;

    logic        clk = 1'b0;
    logic        rst;
    logic        load_start;
    cnt_t        tile_base_m;
    cnt_t        tile_base_n;
    logic        load_done;
    logic        mem_rd_en;
    xaddr_t      mem_rd_addr;
    logic        mem_grant;
    logic        mem_rd_valid;
    word_t       mem_rd_data;
    logic        buf_busy = 1'b0;
    baddr_t      buf_rd_addr;
    word_t       buf_rd_data;
    int unsigned busy_mode = 0;     // 0 none, 1 short stalls, 2 long stalls
    int unsigned busy_left = 0;
    int unsigned starts_given;      // accepted load_start pulses
    int unsigned dones_seen = 0;
    int unsigned issue_idx = 0;     // reads granted in the running load

    weight_load_top u_dut (.*);

    ext_mem_model u_mem (
        .clk      (clk),
        .rst      (rst),
        .rd_en    (mem_rd_en),
        .rd_addr  (mem_rd_addr),
        .grant    (mem_grant),
        .rd_valid (mem_rd_valid),
        .rd_data  (mem_rd_data)
    );

    always #20 clk = ~clk;

    // row idx/BURST_LEN of the tile, word idx%BURST_LEN inside that row
    function automatic xaddr_t weight_word_addr(cnt_t m, cnt_t n, int unsigned idx);
        return `WL_WEIGHT_BASE + (n + idx / `WL_BURST_LEN) * (`WL_M * `WL_K * `WL_K)
             + m * (`WL_K * `WL_K) + idx % `WL_BURST_LEN;
    endfunction

    task automatic stop_with_fail(string line);
        $display("%s", line);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    // bus and done checks, sampled before the edge updates the DUT
    always @(posedge clk) begin
        if (!rst && starts_given == dones_seen) begin
            assert (!mem_rd_en && !load_done) else stop_with_fail($sformatf(
                "Error at %0d ns: read or load_done with no load accepted", $time));
        end else if (!rst) begin
            if (mem_rd_en && mem_grant) begin
                assert (issue_idx < `WL_TILE_WORDS && mem_rd_addr
                        == weight_word_addr(tile_base_m, tile_base_n, issue_idx) * 4)
                else stop_with_fail($sformatf("Error at %0d ns: read %0d at %h, expected %h",
                    $time, issue_idx, mem_rd_addr,
                    weight_word_addr(tile_base_m, tile_base_n, issue_idx) * 4));
                issue_idx <= issue_idx + 1;
            end
            if (load_done) begin
                assert (issue_idx == `WL_TILE_WORDS) else stop_with_fail($sformatf(
                    "Error at %0d ns: load_done after %0d reads", $time, issue_idx));
                issue_idx  <= 0;
                dones_seen <= dones_seen + 1;
            end
        end
    end

    // compute side holding the buffer
    always @(negedge clk) begin
        if (busy_left != 0) begin
            busy_left = busy_left - 1;
        end else if (busy_mode == 1 && $urandom_range(7, 0) == 0) begin
            busy_left = $urandom_range(4, 1);
        end else if (busy_mode == 2 && $urandom_range(15, 0) == 0) begin
            busy_left = $urandom_range(120, 40);    // long compute phase
        end
        buf_busy = (busy_left != 0);
    end

    task automatic run_tile(int unsigned mode, bit extra_start);
        int unsigned waited;
        int unsigned i;
        word_t       expect_data;
        // bases stay in 0..4 and differ from the previous tile
        tile_base_m = (tile_base_m + 1 + $urandom_range(3, 0)) % 5;
        tile_base_n = (tile_base_n + 1 + $urandom_range(3, 0)) % 5;
        @(posedge clk);
        busy_mode = mode;
        @(negedge clk);
        load_start   = 1'b1;
        starts_given = starts_given + 1;
        @(negedge clk);
        load_start = 1'b0;
        waited     = 0;
        while (extra_start && issue_idx < 50 && waited < 5000) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (extra_start && issue_idx < 50) begin
            stop_with_fail("Timeout: the load never reached its second row of reads");
        end
        if (extra_start) begin
            load_start = 1'b1;      // mid-burst start, to be ignored
            @(negedge clk);
            load_start = 1'b0;
        end
        waited = 0;
        while (dones_seen != starts_given && waited < 20000) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (dones_seen != starts_given) begin
            stop_with_fail("Timeout: load_done did not arrive within 20000 cycles");
        end
        @(posedge clk);
        busy_mode = 0;
        for (i = 0; i < `WL_TILE_WORDS; i++) begin
            @(negedge clk);
            buf_rd_addr = baddr_t'(i);
            @(negedge clk);
            expect_data = weight_word_addr(tile_base_m, tile_base_n, i) ^ 32'h5a5a0000;
            assert (buf_rd_data == expect_data) else stop_with_fail($sformatf(
                "Error at %0d ns: buffer word %0d is %h, expected %h",
                $time, i, buf_rd_data, expect_data));
        end
    endtask

    initial begin
        void'($urandom(32'hf6877086));
        rst          = 1'b1;
        load_start   = 1'b0;
        tile_base_m  = '0;
        tile_base_n  = '0;
        buf_rd_addr  = '0;
        starts_given = 0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        repeat (10) @(negedge clk);     // bus must stay quiet
        run_tile(1, 1'b1);
        run_tile(2, 1'b0);              // long stalls fill the fifo
        run_tile(0, 1'b0);
        repeat (20) @(negedge clk);     // no late reads or load_done
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- source/weight_buffer_writer.sv
// buffer writer: drains the fifo into the on-chip weight buffer
// the compute side reads the buffer through a registered read port

`timescale 1ns/10ps

`include "weight_load_params.svh"

module weight_buffer_writer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    empty,
    input  weight_load_pkg::word_t  pop_data,
    output logic                    pop,
    input  logic                    ctrl_done,
    input  logic                    buf_busy,
    input  weight_load_pkg::baddr_t buf_rd_addr,
    output weight_load_pkg::word_t  buf_rd_data,
    output logic                    load_done
);

    import weight_load_pkg::*;

    word_t  ram [`WL_TILE_WORDS];
    baddr_t wr_ptr;     // next buffer address to write
    logic   pending;    // all bursts transferred, waiting for the drain

    // one word per cycle unless compute holds the buffer
    assign pop = !empty && !buf_busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr    <= '0;
            pending   <= 1'b0;
            load_done <= 1'b0;
        end else begin
            load_done <= 1'b0;
            if (pending && empty) begin
                // every word of the tile is in the buffer
                load_done <= 1'b1;
                pending   <= 1'b0;
                wr_ptr    <= '0;
            end else begin
                if (ctrl_done) begin
                    pending <= 1'b1;
                end
                if (pop) begin
                    wr_ptr <= wr_ptr + baddr_t'(1);
                end
            end
        end
    end

    // write and compute read ports
    always_ff @(posedge clk) begin
        if (pop) begin
            ram[wr_ptr] <= pop_data;
        end
        buf_rd_data <= ram[buf_rd_addr];    // data one cycle after address
    end

endmodule

//--- source/weight_burst_reader.sv
// burst reader: turns one burst request into word reads on the external port
// returned words go straight into the fifo, several reads may be in flight

`timescale 1ns/10ps

module weight_burst_reader (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        trans_start,
    input  weight_load_pkg::burst_req_t burst_req,
    output logic                        mem_rd_en,
    output weight_load_pkg::xaddr_t     mem_rd_addr,
    input  logic                        mem_grant,
    input  logic                        mem_rd_valid,
    input  weight_load_pkg::word_t      mem_rd_data,
    output logic                        push,
    output weight_load_pkg::word_t      push_data,
    output logic                        trans_done
);

    import weight_load_pkg::*;

    logic   active;     // burst in progress
    cnt_t   issue_cnt;  // reads granted so far
    cnt_t   ret_cnt;    // words pushed so far
    xaddr_t rd_addr;
    logic   rd_fire;
    cnt_t   last_idx;

    assign mem_rd_en   = active && (issue_cnt != burst_req.iolen);
    assign mem_rd_addr = rd_addr;
    assign rd_fire     = mem_rd_en && mem_grant;
    assign last_idx    = burst_req.iolen - cnt_t'(1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active     <= 1'b0;
            issue_cnt  <= '0;
            ret_cnt    <= '0;
            push       <= 1'b0;
            trans_done <= 1'b0;
        end else begin
            push       <= mem_rd_valid;     // data is registered below
            trans_done <= 1'b0;
            if (trans_start) begin
                active    <= 1'b1;
                issue_cnt <= '0;
                ret_cnt   <= '0;
            end else if (active) begin
                if (rd_fire) begin
                    issue_cnt <= issue_cnt + cnt_t'(1);
                end
                if (push) begin
                    ret_cnt <= ret_cnt + cnt_t'(1);
                    if (ret_cnt == last_idx) begin
                        active     <= 1'b0;
                        trans_done <= 1'b1;     // last word went in last cycle
                    end
                end
            end
        end
    end

    // read address and returned data
    always_ff @(posedge clk) begin
        if (trans_start) begin
            rd_addr <= burst_req.raddr;
        end else if (rd_fire) begin
            rd_addr <= rd_addr + xaddr_t'(4);   // next word
        end
        push_data <= mem_rd_data;
    end

endmodule

//--- source/weight_fifo.sv
// word fifo between the burst reader and the buffer writer
// afull tells the controller when less than one burst of room is left

`timescale 1ns/10ps

`include "weight_load_params.svh"

module weight_fifo (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   push,
    input  weight_load_pkg::word_t push_data,
    input  logic                   pop,
    output weight_load_pkg::word_t pop_data,
    output logic                   empty,
    output logic                   afull
);

    import weight_load_pkg::*;

    localparam int PW = $clog2(`WL_FIFO_DEPTH);

    word_t         mem [`WL_FIFO_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   count;   // occupancy, one bit wider than the pointers
    logic          do_push;
    logic          do_pop;

    assign empty    = (count == '0);
    assign do_push  = push && (count != (PW+1)'(`WL_FIFO_DEPTH));
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];  // head word, no read latency

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            afull  <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;    // wraps at depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            afull <= (count > (PW+1)'(`WL_FIFO_AFULL));
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

//--- source/weight_load_ctrl.sv
// load controller: walks the TN rows of a tile and issues one burst per row
// row address follows the weight layout of the external memory

`timescale 1ns/10ps

`include "weight_load_params.svh"

module weight_load_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       load_start,
    input  weight_load_pkg::cnt_t      tile_base_m,
    input  weight_load_pkg::cnt_t      tile_base_n,
    input  logic                       fifo_afull,
    input  logic                       trans_done,
    output logic                       trans_start,
    output weight_load_pkg::burst_req_t burst_req,
    output logic                       ctrl_done
);

    import weight_load_pkg::*;

    load_state_t state;
    load_state_t state_next;
    cnt_t        row_cnt;       // row of the tile being loaded
    logic        last_row;      // set once the final row is configured
    xaddr_t      row_word_addr;

    // word address of the first weight of the current row
    assign row_word_addr = xaddr_t'(`WL_WEIGHT_BASE)
                         + (xaddr_t'(tile_base_n) + xaddr_t'(row_cnt)) * (`WL_M * `WL_K * `WL_K)
                         + xaddr_t'(tile_base_m) * (`WL_K * `WL_K);

    always_comb begin
        state_next = state;
        case (state)
            LS_IDLE: begin
                if (load_start) begin
                    state_next = fifo_afull ? LS_WAIT_ROOM : LS_CONFIG;
                end
            end
            LS_WAIT_ROOM: begin
                if (!fifo_afull) begin
                    state_next = LS_CONFIG;
                end
            end
            LS_CONFIG: state_next = LS_TRANS;
            LS_TRANS: begin
                if (trans_done) begin
                    state_next = LS_DONE;
                end
            end
            LS_DONE: begin
                if (last_row) begin
                    state_next = LS_IDLE;
                end else if (fifo_afull) begin
                    state_next = LS_WAIT_ROOM;  // let the writer drain first
                end else begin
                    state_next = LS_CONFIG;
                end
            end
            default: state_next = LS_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= LS_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // row counter and last-row flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            row_cnt  <= '0;
            last_row <= 1'b0;
        end else if (ctrl_done) begin
            row_cnt  <= '0;
            last_row <= 1'b0;
        end else if (state == LS_CONFIG) begin
            row_cnt <= row_cnt + cnt_t'(1);
            if (row_cnt == cnt_t'(`WL_TN - 1)) begin
                last_row <= 1'b1;
            end
        end
    end

    // burst parameters, captured in config
    always_ff @(posedge clk) begin
        if (state == LS_CONFIG) begin
            burst_req.raddr <= {row_word_addr[`WL_XAW-3:0], 2'b00};  // words to bytes
            burst_req.iolen <= cnt_t'(`WL_BURST_LEN);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            trans_start <= 1'b0;
            ctrl_done   <= 1'b0;
        end else begin
            trans_start <= (state == LS_CONFIG);            // one cycle after config
            ctrl_done   <= (state == LS_DONE) && last_row;
        end
    end

endmodule

//--- source/weight_load_params.svh
// sizes of the layer, the tile and the memory map for the weight loader
// include wherever a size or the weight base address is needed

`ifndef WEIGHT_LOAD_PARAMS_SVH
`define WEIGHT_LOAD_PARAMS_SVH

// layer and tile
`define WL_M            8       // total output channels
`define WL_K            3       // kernel size
`define WL_TN           4       // rows per tile
`define WL_TM           4       // channels per row burst

// one burst per row, TM*K*K words
`define WL_BURST_LEN    (`WL_TM * `WL_K * `WL_K)
`define WL_TILE_WORDS   (`WL_TN * `WL_BURST_LEN)

// word base of the weights in external memory
`define WL_WEIGHT_BASE  131072

// fifo keeps room for a full burst below the almost-full mark
`define WL_FIFO_DEPTH   64
`define WL_FIFO_AFULL   (`WL_FIFO_DEPTH - `WL_BURST_LEN)

// widths
`define WL_XAW          32      // external byte address
`define WL_CW           16      // counters and indices
`define WL_DW           32      // weight word
`define WL_BAW          8       // weight buffer address

`endif

//--- source/weight_load_pkg.sv
// types shared by the weight loader blocks
// modules name these as weight_load_pkg::<type> in their port lists

`include "weight_load_params.svh"

package weight_load_pkg;

    // external byte address
    typedef logic [`WL_XAW-1:0] xaddr_t;

    // tile base, row index, burst length
    typedef logic [`WL_CW-1:0] cnt_t;

    typedef logic [`WL_DW-1:0] word_t;     // one weight word

    typedef logic [`WL_BAW-1:0] baddr_t;   // weight buffer address

    // load controller states
    typedef enum logic [2:0] {
        LS_IDLE,
        LS_CONFIG,      // compute row address and length
        LS_WAIT_ROOM,   // fifo too full for another burst
        LS_TRANS,       // burst running in the reader
        LS_DONE         // burst finished, pick next row or stop
    } load_state_t;

    // one burst request, held stable by the controller
    // from trans_start until trans_done
    typedef struct packed {
        xaddr_t raddr;  // byte address of the first word
        cnt_t   iolen;  // number of words
    } burst_req_t;

endpackage

//--- source/weight_load_top.sv
// top of the weight loader for one tile
// controller -> burst reader -> fifo -> buffer writer

`timescale 1ns/10ps

module weight_load_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load_start,
    input  weight_load_pkg::cnt_t   tile_base_m,
    input  weight_load_pkg::cnt_t   tile_base_n,
    output logic                    load_done,
    output logic                    mem_rd_en,
    output weight_load_pkg::xaddr_t mem_rd_addr,
    input  logic                    mem_grant,
    input  logic                    mem_rd_valid,
    input  weight_load_pkg::word_t  mem_rd_data,
    input  logic                    buf_busy,
    input  weight_load_pkg::baddr_t buf_rd_addr,
    output weight_load_pkg::word_t  buf_rd_data
);

    import weight_load_pkg::*;

    burst_req_t burst_req;
    logic       trans_start;
    logic       trans_done;
    logic       ctrl_done;
    logic       fifo_push;
    word_t      fifo_push_data;
    logic       fifo_pop;
    word_t      fifo_pop_data;
    logic       fifo_empty;
    logic       fifo_afull;

    weight_load_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .load_start  (load_start),
        .tile_base_m (tile_base_m),
        .tile_base_n (tile_base_n),
        .fifo_afull  (fifo_afull),
        .trans_done  (trans_done),
        .trans_start (trans_start),
        .burst_req   (burst_req),
        .ctrl_done   (ctrl_done)
    );

    weight_burst_reader u_reader (
        .clk          (clk),
        .rst          (rst),
        .trans_start  (trans_start),
        .burst_req    (burst_req),
        .mem_rd_en    (mem_rd_en),
        .mem_rd_addr  (mem_rd_addr),
        .mem_grant    (mem_grant),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_data  (mem_rd_data),
        .push         (fifo_push),
        .push_data    (fifo_push_data),
        .trans_done   (trans_done)
    );

    weight_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (fifo_push),
        .push_data (fifo_push_data),
        .pop       (fifo_pop),
        .pop_data  (fifo_pop_data),
        .empty     (fifo_empty),
        .afull     (fifo_afull)
    );

    weight_buffer_writer u_writer (
        .clk         (clk),
        .rst         (rst),
        .empty       (fifo_empty),
        .pop_data    (fifo_pop_data),
        .pop         (fifo_pop),
        .ctrl_done   (ctrl_done),
        .buf_busy    (buf_busy),
        .buf_rd_addr (buf_rd_addr),
        .buf_rd_data (buf_rd_data),
        .load_done   (load_done)
    );

endmodule

//--- weight_load_top.f
+incdir+source
source/weight_load_pkg.sv
source/weight_fifo.sv
source/weight_load_ctrl.sv
source/weight_burst_reader.sv
source/weight_buffer_writer.sv
source/weight_load_top.sv
bench/ext_mem_model.sv
bench/tb_weight_load.sv
